//--- logic/chiplet_rx_consts.svh
`ifndef CHIPLET_RX_CONSTS_SVH
`define CHIPLET_RX_CONSTS_SVH

// Flit and bus word width.
`define CRX_WORD_W 32

// Receive buffer holds 2**CRX_BUF_AW words.
`define CRX_BUF_AW 8
`define CRX_META_DEPTH 4
`define CRX_NUM_VC 4

// CRC-32, MSB first, unreflected, no final XOR.
`define CRX_CRC_POLY 32'h04C1_1DB7
`define CRX_CRC_INIT 32'hFFFF_FFFF

`endif

//--- logic/chiplet_rx_pkg.sv
`include "chiplet_rx_consts.svh"

package chiplet_rx_pkg;

    // The header word. data_words counts the words between header and CRC.
    typedef struct packed {
        logic [3:0]  data_words;
        logic [3:0]  dest;
        logic [23:0] tag;
    } rx_header_t;

    // One flit word, read as a header or as raw payload.
    typedef union packed {
        rx_header_t             hdr;
        logic [`CRX_WORD_W-1:0] raw;
    } flit_word_u;

    // Word count covers the header and the data words.
    typedef struct packed {
        logic [3:0]             id;
        logic [2:0]             req;
        logic [`CRX_BUF_AW-1:0] start_addr;
        logic [4:0]             word_count;
        logic [3:0]             pad;
    } meta_entry_t;

    typedef enum logic [11:0] {
        REG_STATUS   = 12'h000,
        REG_META     = 12'h004,
        REG_ERR_CLR  = 12'h008,
        REG_BUF_BASE = 12'h400
    } host_reg_e;

endpackage

//--- logic/rx_buf_if.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

interface rx_buf_if;
    logic                     wen;
    logic [`CRX_BUF_AW-1:0]   waddr;
    logic [`CRX_WORD_W-1:0]   wdata;
    logic [`CRX_WORD_W/8-1:0] strobe;

    modport writer (
        output wen,
        output waddr,
        output wdata,
        output strobe
    );

    modport memory (
        input wen,
        input waddr,
        input wdata,
        input strobe
    );
endinterface

//--- logic/rx_crc.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module rx_crc (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   clear,
    input  logic                   update,
    input  logic [`CRX_WORD_W-1:0] data,
    output logic [31:0]            crc,
    output logic                   done
);
    logic [23:0] rest;
    logic [1:0]  bytes_left;

    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {b, 24'h0};
        for (int i = 0; i < 8; i++) begin
            r = r[31] ? ((r << 1) ^ `CRX_CRC_POLY) : (r << 1);
        end
        return r;
    endfunction

    // The top byte is folded on the update edge, the other three follow.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc        <= `CRX_CRC_INIT;
            done       <= 1'b0;
            bytes_left <= 2'd0;
        end else if (clear) begin
            crc        <= `CRX_CRC_INIT;
            done       <= 1'b0;
            bytes_left <= 2'd0;
        end else if (update) begin
            crc        <= crc_byte(crc, data[31:24]);
            done       <= 1'b0;
            bytes_left <= 2'd3;
        end else if (bytes_left != 2'd0) begin
            crc        <= crc_byte(crc, rest[23:16]);
            done       <= (bytes_left == 2'd1);
            bytes_left <= bytes_left - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            rest <= data[23:0];
        end else begin
            rest <= rest << 8;
        end
    end
endmodule

//--- logic/rx_fsm.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module rx_fsm (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        flit_valid,
    input  chiplet_rx_pkg::flit_word_u  flit_data,
    input  logic [1:0]                  flit_vc,
    input  logic [3:0]                  flit_id,
    input  logic [2:0]                  flit_req,
    output logic                        flit_pop,
    output logic [`CRX_NUM_VC-1:0]      credit,
    output logic                        crc_error,
    output logic                        meta_push,
    output chiplet_rx_pkg::meta_entry_t meta_entry,
    input  logic                        meta_full,
    rx_buf_if.writer                    buf_port
);
    typedef enum logic [2:0] {
        IDLE, HEADER, CRC_WAIT, BODY, CRC_CHECK, COMMIT
    } state_e;

    state_e                 state, next_state;
    logic [`CRX_BUF_AW-1:0] waddr, next_waddr;
    logic [`CRX_BUF_AW-1:0] start_addr, next_start_addr;
    logic [3:0]             words_left, next_words_left;
    logic [3:0]             pkt_len;
    logic [3:0]             pkt_id;
    logic [2:0]             pkt_req;
    logic                   crc_clear, crc_update, crc_done;
    logic [31:0]            crc_val;

    rx_crc crc_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (crc_clear),
        .update (crc_update),
        .data   (flit_data.raw),
        .crc    (crc_val),
        .done   (crc_done)
    );

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            waddr      <= '0;
            start_addr <= '0;
            words_left <= '0;
        end else begin
            state      <= next_state;
            waddr      <= next_waddr;
            start_addr <= next_start_addr;
            words_left <= next_words_left;
        end
    end

    always_ff @(posedge clk) begin
        if (state == HEADER) begin
            pkt_len <= flit_data.hdr.data_words;
            pkt_id  <= flit_id;
            pkt_req <= flit_req;
        end
    end

    always_comb begin
        next_state      = state;
        next_waddr      = waddr;
        next_start_addr = start_addr;
        next_words_left = words_left;
        crc_clear       = 1'b0;
        crc_update      = 1'b0;
        flit_pop        = 1'b0;
        crc_error       = 1'b0;
        meta_push       = 1'b0;
        buf_port.wen    = 1'b0;
        case (state)
            IDLE: begin
                crc_clear = 1'b1;
                if (flit_valid) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                crc_update      = 1'b1;
                next_words_left = flit_data.hdr.data_words;
                next_state      = CRC_WAIT;
            end
            CRC_WAIT: begin
                // The word is held by the switch until its CRC pass is over.
                if (crc_done) begin
                    flit_pop     = 1'b1;
                    buf_port.wen = 1'b1;
                    next_waddr   = waddr + 1'b1;
                    if (words_left == 4'd0) begin
                        next_state = CRC_CHECK;
                    end else begin
                        next_words_left = words_left - 4'd1;
                        next_state      = BODY;
                    end
                end
            end
            BODY: begin
                if (flit_valid) begin
                    crc_update = 1'b1;
                    next_state = CRC_WAIT;
                end
            end
            CRC_CHECK: begin
                if (flit_valid) begin
                    flit_pop = 1'b1;
                    if (flit_data.raw == crc_val) begin
                        next_state = COMMIT;
                    end else begin
                        crc_error  = 1'b1;
                        next_waddr = start_addr;
                        next_state = IDLE;
                    end
                end
            end
            COMMIT: begin
                // Stalls here while the host leaves the queue full.
                if (!meta_full) begin
                    meta_push       = 1'b1;
                    next_start_addr = waddr;
                    next_state      = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        credit          = '0;
        credit[flit_vc] = flit_pop;
    end

    assign buf_port.waddr  = waddr;
    assign buf_port.wdata  = flit_data.raw;
    assign buf_port.strobe = '1;

    assign meta_entry.id         = pkt_id;
    assign meta_entry.req        = pkt_req;
    assign meta_entry.start_addr = start_addr;
    assign meta_entry.word_count = {1'b0, pkt_len} + 5'd1;
    assign meta_entry.pad        = '0;
endmodule

//--- logic/rx_buffer_ram.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module rx_buffer_ram (
    input  logic                   clk,
    rx_buf_if.memory               buf_port,
    input  logic [`CRX_BUF_AW-1:0] raddr,
    output logic [`CRX_WORD_W-1:0] rdata
);
    localparam int DEPTH = 1 << `CRX_BUF_AW;
    localparam int LANES = `CRX_WORD_W / 8;

    logic [`CRX_WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (buf_port.wen) begin
            for (int b = 0; b < LANES; b++) begin
                if (buf_port.strobe[b]) begin
                    mem[buf_port.waddr][8*b +: 8] <= buf_port.wdata[8*b +: 8];
                end
            end
        end
    end

    // Host side read, data one cycle after the address.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end
endmodule

//--- logic/rx_host_apb.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module rx_host_apb (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [11:0]                 paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        meta_push,
    input  chiplet_rx_pkg::meta_entry_t meta_entry,
    output logic                        meta_full,
    input  logic                        crc_error,
    output logic [`CRX_BUF_AW-1:0]      raddr,
    input  logic [31:0]                 rdata
);
    localparam int QAW = $clog2(`CRX_META_DEPTH);
    localparam logic [QAW:0] FULL_LEVEL = `CRX_META_DEPTH;

    chiplet_rx_pkg::meta_entry_t queue [`CRX_META_DEPTH];
    logic [QAW-1:0] wr_ptr, rd_ptr;
    logic [QAW:0]   fill;
    logic [7:0]     err_cnt;
    logic           access, buf_sel, buf_wait;
    logic           q_push, q_pop, err_clr;

    assign access    = psel && penable;
    assign buf_sel   = (paddr & 12'hC00) == chiplet_rx_pkg::REG_BUF_BASE;
    assign raddr     = paddr[`CRX_BUF_AW+1:2];
    assign meta_full = (fill == FULL_LEVEL);
    assign q_push    = meta_push && !meta_full;

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        q_pop   = 1'b0;
        err_clr = 1'b0;
        if (access && buf_sel) begin
            // RAM data is taken in the second access cycle.
            pready  = buf_wait;
            pslverr = buf_wait && pwrite;
            prdata  = rdata;
        end else if (access) begin
            pready = 1'b1;
            case (paddr)
                chiplet_rx_pkg::REG_STATUS: begin
                    prdata[QAW:0]  = fill;
                    prdata[15:8]   = err_cnt;
                    pslverr        = pwrite;
                end
                chiplet_rx_pkg::REG_META: begin
                    if (pwrite || fill == '0) begin
                        pslverr = 1'b1;
                    end else begin
                        prdata = {8'h0, queue[rd_ptr]};
                        q_pop  = 1'b1;
                    end
                end
                chiplet_rx_pkg::REG_ERR_CLR: begin
                    err_clr = pwrite && pwdata[0];
                end
                default: begin
                    pslverr = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            queue[wr_ptr] <= meta_entry;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            err_cnt  <= '0;
            buf_wait <= 1'b0;
        end else begin
            buf_wait <= access && buf_sel && !buf_wait;
            if (q_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (q_push && !q_pop) begin
                fill <= fill + 1'b1;
            end else if (q_pop && !q_push) begin
                fill <= fill - 1'b1;
            end
            if (err_clr) begin
                err_cnt <= '0;
            end else if (crc_error && err_cnt != 8'hFF) begin
                err_cnt <= err_cnt + 8'd1;
            end
        end
    end
endmodule

//--- logic/chiplet_rx_top.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module chiplet_rx_top (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   flit_valid,
    input  logic [`CRX_WORD_W-1:0] flit_data,
    input  logic [1:0]             flit_vc,
    input  logic [3:0]             flit_id,
    input  logic [2:0]             flit_req,
    output logic                   flit_pop,
    output logic [`CRX_NUM_VC-1:0] credit,
    output logic                   crc_error,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [11:0]            paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);
    chiplet_rx_pkg::meta_entry_t meta_entry;
    logic                        meta_push;
    logic                        meta_full;
    logic [`CRX_BUF_AW-1:0]      raddr;
    logic [`CRX_WORD_W-1:0]      rdata;

    rx_buf_if buf_bus ();

    rx_fsm fsm_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .flit_data  (flit_data),
        .flit_vc    (flit_vc),
        .flit_id    (flit_id),
        .flit_req   (flit_req),
        .flit_pop   (flit_pop),
        .credit     (credit),
        .crc_error  (crc_error),
        .meta_push  (meta_push),
        .meta_entry (meta_entry),
        .meta_full  (meta_full),
        .buf_port   (buf_bus.writer)
    );

    rx_buffer_ram ram_i (
        .clk      (clk),
        .buf_port (buf_bus.memory),
        .raddr    (raddr),
        .rdata    (rdata)
    );

    rx_host_apb host_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .meta_push  (meta_push),
        .meta_entry (meta_entry),
        .meta_full  (meta_full),
        .crc_error  (crc_error),
        .raddr      (raddr),
        .rdata      (rdata)
    );
endmodule

//--- verif/chiplet_rx_sva.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module chiplet_rx_sva (
    input logic                   clk,
    input logic                   n_rst,
    input logic                   flit_valid,
    input logic                   flit_pop,
    input logic [`CRX_NUM_VC-1:0] credit,
    input logic                   psel,
    input logic                   penable,
    input logic                   pready,
    input logic                   meta_push,
    input logic                   meta_full
);
    pop_needs_valid: assert property (@(posedge clk) disable iff (!n_rst)
        flit_pop |-> flit_valid)
        else $error("flit_pop without flit_valid");

    // One credit per popped word, never without a pop.
    credit_with_pop: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(credit) && ((credit != '0) == flit_pop))
        else $error("credit not one-hot with flit_pop");

    ready_in_access: assert property (@(posedge clk) disable iff (!n_rst)
        pready |-> psel && penable)
        else $error("pready outside the APB access phase");

    no_push_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        meta_push |-> !meta_full)
        else $error("meta_push while the queue is full");
endmodule

bind chiplet_rx_top chiplet_rx_sva sva_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .flit_valid (flit_valid),
    .flit_pop   (flit_pop),
    .credit     (credit),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .meta_push  (meta_push),
    .meta_full  (meta_full)
);

//--- verif/chiplet_rx_tb.sv
`timescale 1ns/100ps
`include "chiplet_rx_consts.svh"

module chiplet_rx_tb;
    logic                   clk;
    logic                   n_rst;
    logic                   flit_valid;
    logic [`CRX_WORD_W-1:0] flit_data;
    logic [1:0]             flit_vc;
    logic [3:0]             flit_id;
    logic [2:0]             flit_req;
    logic                   flit_pop;
    logic [`CRX_NUM_VC-1:0] credit;
    logic                   crc_error;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [11:0]            paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    logic [15:0]                 lfsr_state;
    logic [7:0]                  next_start = '0;
    int                          total_words = 0;
    int                          pkts_sent = 0;
    int                          err_pulses = 0;
    int                          credit_seen [`CRX_NUM_VC];
    int                          words_sent [`CRX_NUM_VC];
    chiplet_rx_pkg::meta_entry_t exp_meta [$];
    logic [31:0]                 exp_words [$];

    chiplet_rx_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_meta(input string name, input chiplet_rx_pkg::meta_entry_t exp,
                              input chiplet_rx_pkg::meta_entry_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected id=%h req=%h start=%h count=%0d pad=%h,",
                     $time, name, exp.id, exp.req, exp.start_addr, exp.word_count, exp.pad);
            $display("    actual id=%h req=%h start=%h count=%0d pad=%h",
                     act.id, act.req, act.start_addr, act.word_count, act.pad);
            abort_run();
        end
    endtask

    // 16-bit Fibonacci LFSR, taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
    endtask

    // Bitwise CRC-32, MSB first, so a word is folded from bit 31 down.
    function automatic logic [31:0] crc_ref(input logic [31:0] crc, input logic [31:0] word);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ word[i];
            c  = c << 1;
            if (fb) begin
                c = c ^ `CRX_CRC_POLY;
            end
        end
        return c;
    endfunction

    // Holds the word until the DUT pops it, then returns on the next falling edge.
    task automatic push_word(input logic [31:0] word);
        flit_valid = 1'b1;
        flit_data  = word;
        #1;
        while (!flit_pop) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waits;
        int exp_waits;
        waits = 0;
        // Buffer window reads take one wait state, register accesses none.
        exp_waits = (addr >= chiplet_rx_pkg::REG_BUF_BASE) ? 1 : 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
            waits++;
        end
        check_word("pready wait states", exp_waits, waits);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_packet(input logic corrupt);
        chiplet_rx_pkg::rx_header_t  hdr;
        chiplet_rx_pkg::flit_word_u  fw;
        chiplet_rx_pkg::meta_entry_t entry;
        logic [31:0]                 r;
        logic [31:0]                 crc;
        logic [31:0]                 words [$];
        pkts_sent++;
        rand_bits(2, r);
        flit_vc = r[1:0];
        rand_bits(4, r);
        flit_id = r[3:0];
        rand_bits(3, r);
        flit_req = r[2:0];
        rand_bits(4, r);
        hdr.data_words = r[3:0];
        rand_bits(4, r);
        hdr.dest = r[3:0];
        rand_bits(24, r);
        hdr.tag = r[23:0];
        fw.hdr = hdr;
        words.push_back(fw.raw);
        for (int i = 0; i < hdr.data_words; i++) begin
            rand_bits(32, r);
            words.push_back(r);
        end
        crc = `CRX_CRC_INIT;
        foreach (words[i]) begin
            crc = crc_ref(crc, words[i]);
            push_word(words[i]);
        end
        push_word(corrupt ? crc ^ 32'h0000_0100 : crc);
        flit_valid = 1'b0;
        words_sent[flit_vc] += words.size() + 1;
        if (!corrupt) begin
            entry.id         = flit_id;
            entry.req        = flit_req;
            entry.start_addr = next_start;
            entry.word_count = 5'(words.size());
            entry.pad        = '0;
            exp_meta.push_back(entry);
            foreach (words[i]) begin
                exp_words.push_back(words[i]);
            end
            next_start  = next_start + 8'(words.size());
            total_words = total_words + words.size();
        end
    endtask

    task automatic wait_fill(input int level);
        logic [31:0] rd;
        logic        err;
        int          polls;
        rd    = '0;
        polls = 0;
        while ({29'h0, rd[2:0]} < level) begin
            if (polls == 100) begin
                $display("Metadata queue never reached %0d entries", level);
                abort_run();
            end
            apb_access(1'b0, chiplet_rx_pkg::REG_STATUS, '0, rd, err);
            polls++;
        end
    endtask

    task automatic wait_err(input int count);
        int cycles;
        cycles = 0;
        while (err_pulses != count) begin
            if (cycles == 50) begin
                $display("No crc_error pulse after the corrupted packet");
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_status(input logic [2:0] fill, input logic [7:0] errs);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, chiplet_rx_pkg::REG_STATUS, '0, rd, err);
        check_bit("pslverr on REG_STATUS", 1'b0, err);
        check_word("REG_STATUS", {16'h0, errs, 5'h0, fill}, rd);
    endtask

    // Pops one entry and reads its words back through the buffer window.
    task automatic read_packet();
        chiplet_rx_pkg::meta_entry_t exp;
        chiplet_rx_pkg::meta_entry_t got;
        logic [31:0]                 rd;
        logic                        err;
        logic [7:0]                  addr;
        wait_fill(1);
        apb_access(1'b0, chiplet_rx_pkg::REG_META, '0, rd, err);
        check_bit("pslverr on REG_META", 1'b0, err);
        got = chiplet_rx_pkg::meta_entry_t'(rd[23:0]);
        exp = exp_meta.pop_front();
        check_meta("REG_META", exp, got);
        for (int i = 0; i < exp.word_count; i++) begin
            addr = exp.start_addr + 8'(i);
            apb_access(1'b0, {2'b01, addr, 2'b00}, '0, rd, err);
            check_bit("pslverr on buffer read", 1'b0, err);
            check_word("buffer word", exp_words.pop_front(), rd);
        end
    endtask

    initial begin : pulse_monitor
        forever begin
            @(negedge clk);
            #1;
            if (n_rst) begin
                for (int v = 0; v < `CRX_NUM_VC; v++) begin
                    if (credit[v]) begin
                        credit_seen[v]++;
                    end
                end
                if (crc_error) begin
                    err_pulses++;
                end
            end
        end
    end

    // Budget grows with every packet sent.
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 200 * pkts_sent + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d packets sent", cycles, pkts_sent);
        abort_run();
    end

    initial begin : main_seq
        logic [31:0] rd;
        logic        err;
        lfsr_state = 16'd38268;
        for (int v = 0; v < `CRX_NUM_VC; v++) begin
            credit_seen[v] = 0;
            words_sent[v]  = 0;
        end
        flit_valid = 1'b0;
        flit_data  = '0;
        flit_vc    = '0;
        flit_id    = '0;
        flit_req   = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        n_rst      = 1'b0;
        repeat (2) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        apb_access(1'b0, chiplet_rx_pkg::REG_META, '0, rd, err);
        check_bit("pslverr on empty REG_META", 1'b1, err);
        apb_access(1'b0, 12'h00C, '0, rd, err);
        check_bit("pslverr on unmapped address", 1'b1, err);
        apb_access(1'b1, chiplet_rx_pkg::REG_STATUS, 32'h1, rd, err);
        check_bit("pslverr on REG_STATUS write", 1'b1, err);
        check_status(3'd0, 8'd0);

        // Enough traffic to wrap the buffer address.
        while (total_words < 300) begin
            send_packet(1'b0);
            read_packet();
        end

        // The model start address does not move for the corrupted packet.
        send_packet(1'b1);
        wait_err(1);
        check_status(3'd0, 8'd1);
        send_packet(1'b0);
        read_packet();

        // The fifth packet stalls in commit until the host frees an entry.
        repeat (5) send_packet(1'b0);
        wait_fill(4);
        check_status(3'd4, 8'd1);
        repeat (5) read_packet();
        check_status(3'd0, 8'd1);

        apb_access(1'b1, chiplet_rx_pkg::REG_ERR_CLR, 32'h1, rd, err);
        check_bit("pslverr on REG_ERR_CLR write", 1'b0, err);
        check_status(3'd0, 8'd0);

        for (int v = 0; v < `CRX_NUM_VC; v++) begin
            check_word($sformatf("credit count vc%0d", v), words_sent[v], credit_seen[v]);
        end
        $display("No errors");
        $finish;
    end
endmodule

//--- chiplet_rx.f
+incdir+logic
logic/chiplet_rx_pkg.sv
logic/rx_buf_if.sv
logic/rx_crc.sv
logic/rx_fsm.sv
logic/rx_buffer_ram.sv
logic/rx_host_apb.sv
logic/chiplet_rx_top.sv
verif/chiplet_rx_sva.sv
verif/chiplet_rx_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := chiplet_rx_tb
FILELIST  := chiplet_rx.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
